// File: src/busPkg.sv
// Read-only subset of an AHB-style bus: no writes, no burst size field,
// no error, split or retry responses
`default_nettype none

package busPkg;

  // Byte address and data word widths
  localparam int addrBits = 32;
  localparam int dataBits = 32;

  // Address phase kinds, AHB encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } transType;

endpackage

`default_nettype wire

// File: src/cachePkg.sv
// Line geometry for the instruction cache. Lines are 16 bytes of 32-bit words
// and the set count comes from the setBits parameter of the top level
`default_nettype none

package cachePkg;

  // Words in one cache line
  localparam int wordsPerLine = 4;

  // Byte offset within a line
  localparam int offsetBits = 4;

  // Controller states
  // READY      idle or serving hits
  // MEMREAD    address phases of a fill still to be issued
  // LASTREAD   last address sent, waiting for the final data beat
  // NEXTINSTR  one cycle delivering the filled or bypassed word
  typedef enum logic [1:0] {
    READY,
    MEMREAD,
    LASTREAD,
    NEXTINSTR
  } ctrlState;

endpackage

`default_nettype wire

// File: src/cacheController.sv
// Miss handling for the two-way instruction cache. Fills always start at word 0
// and take four beats. Disabled fetches use one single read and bypass the arrays
`timescale 1ns/1ns
`default_nettype none

module cacheController #(
  parameter int setBits = 6
) (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              cacheEnable,
  input  wire logic                              fetchValid,
  input  wire logic [busPkg::addrBits-1:0]       fetchAddr,
  input  wire logic                              way1Valid,
  input  wire logic                              way2Valid,
  input  wire logic [busPkg::addrBits-setBits-cachePkg::offsetBits-1:0] way1Tag,
  input  wire logic [busPkg::addrBits-setBits-cachePkg::offsetBits-1:0] way2Tag,
  input  wire logic                              lruBit,
  input  wire logic                              busReady,
  output logic                                   stall,
  output logic [busPkg::addrBits-1:0]            busAddr,
  output busPkg::transType                       busTrans,
  output logic                                   way1WriteEn,
  output logic                                   way2WriteEn,
  output logic                                   tagWrite,
  output logic [$clog2(cachePkg::wordsPerLine)-1:0] fillWordOffset,
  output logic                                   readWay,
  output logic                                   bypassLoad,
  output logic                                   readBypass,
  output logic                                   lruUpdate,
  output logic                                   lruWay
);

  localparam int tagBits = busPkg::addrBits - setBits - cachePkg::offsetBits;
  localparam int wordSelBits = $clog2(cachePkg::wordsPerLine);
  localparam int byteBits = cachePkg::offsetBits - wordSelBits;
  localparam logic [wordSelBits-1:0] lastWord = wordSelBits'(cachePkg::wordsPerLine - 1);

  cachePkg::ctrlState state, nextState;

  logic [tagBits-1:0]     fetchTag;
  logic                   way1Hit, way2Hit, hit;
  logic                   missStart;
  logic                   victimNext, victimWay;
  logic                   bypassMode;
  logic                   fillBeat;
  logic [wordSelBits-1:0] addrCount, addrWord;

  // Hit detection, only meaningful while caching is enabled
  assign fetchTag = fetchAddr[busPkg::addrBits-1 -: tagBits];
  assign way1Hit = way1Valid && (way1Tag == fetchTag);
  assign way2Hit = way2Valid && (way2Tag == fetchTag);
  assign hit = fetchValid && cacheEnable && (way1Hit || way2Hit);

  // A disabled fetch goes to the bus even when a way happens to match
  assign missStart = (state == cachePkg::READY) && fetchValid && !(cacheEnable && hit);

  // Invalid way first, way 1 before way 2, else the LRU choice
  assign victimNext = !way1Valid ? 1'b0 : (!way2Valid ? 1'b1 : lruBit);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= cachePkg::READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::READY: begin
        if (missStart && busReady) begin
          nextState = cacheEnable ? cachePkg::MEMREAD : cachePkg::LASTREAD;
        end
      end
      cachePkg::MEMREAD: begin
        if (busReady && addrCount == lastWord) begin
          nextState = cachePkg::LASTREAD;
        end
      end
      cachePkg::LASTREAD: begin
        if (busReady) begin
          nextState = cachePkg::NEXTINSTR;
        end
      end
      default: nextState = cachePkg::READY;
    endcase
  end

  // Victim and mode are frozen once the first address phase is taken
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      victimWay <= 1'b0;
      bypassMode <= 1'b0;
    end else if (missStart && busReady) begin
      victimWay <= victimNext;
      bypassMode <= !cacheEnable;
    end
  end

  // Address-phase word counter
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      addrCount <= '0;
    end else if (state == cachePkg::READY || state == cachePkg::NEXTINSTR) begin
      addrCount <= (nextState == cachePkg::MEMREAD) ? wordSelBits'(1) : '0;
    end else if (state == cachePkg::MEMREAD && busReady) begin
      addrCount <= addrCount + 1'b1;
    end
  end

  // Data beat lags the address phase by one, wraps to the last word in LASTREAD
  assign fillWordOffset = addrCount - 1'b1;

  // Word 0 for a fill, the requested word for a bypass read
  always_comb begin
    if (state == cachePkg::READY) begin
      addrWord = cacheEnable ? '0 : fetchAddr[byteBits +: wordSelBits];
    end else begin
      addrWord = addrCount;
    end
  end

  assign busAddr = {fetchAddr[busPkg::addrBits-1:cachePkg::offsetBits], addrWord,
                    {byteBits{1'b0}}};

  always_comb begin
    case (state)
      cachePkg::READY:   busTrans = missStart ? busPkg::NONSEQ : busPkg::IDLE;
      cachePkg::MEMREAD: busTrans = busPkg::SEQ;
      default:           busTrans = busPkg::IDLE;
    endcase
  end

  assign stall = missStart || state == cachePkg::MEMREAD || state == cachePkg::LASTREAD;

  // Fill writes and the bypass capture
  assign fillBeat = busReady && (state == cachePkg::MEMREAD ||
                                 (state == cachePkg::LASTREAD && !bypassMode));
  assign way1WriteEn = fillBeat && !victimWay;
  assign way2WriteEn = fillBeat && victimWay;
  assign tagWrite = busReady && state == cachePkg::LASTREAD && !bypassMode;
  assign bypassLoad = busReady && state == cachePkg::LASTREAD && bypassMode;

  // Way 2 is 1 on readWay and lruWay
  assign readWay = (state == cachePkg::NEXTINSTR) ? victimWay : way2Hit;
  assign readBypass = (state == cachePkg::NEXTINSTR) && bypassMode;
  assign lruUpdate = (state == cachePkg::READY && hit) ||
                     (state == cachePkg::NEXTINSTR && !bypassMode);
  assign lruWay = readWay;

  // Processor must hold its request across a stall
  assert property (@(posedge clk) disable iff (reset) stall |=> $stable(fetchAddr))
    else $error("fetchAddr changed while stalled");

  // Last data beat leads to the delivery cycle, which starts no new transfer
  assert property (@(posedge clk) disable iff (reset)
                   state == cachePkg::LASTREAD && busReady |=>
                   state == cachePkg::NEXTINSTR && busTrans == busPkg::IDLE)
    else $error("bus transfer issued in NEXTINSTR");

endmodule

`default_nettype wire

// File: src/cacheWays.sv
// Tag, valid and data storage for both ways. Only valid bits are reset,
// so a line reads as garbage until its fill completes
`timescale 1ns/1ns
`default_nettype none

module cacheWays #(
  parameter int setBits = 6
) (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic [busPkg::addrBits-1:0]       fetchAddr,
  input  wire logic [busPkg::dataBits-1:0]       busRdata,
  input  wire logic                              way1WriteEn,
  input  wire logic                              way2WriteEn,
  input  wire logic                              tagWrite,
  input  wire logic [$clog2(cachePkg::wordsPerLine)-1:0] fillWordOffset,
  input  wire logic                              readWay,
  input  wire logic                              bypassLoad,
  input  wire logic                              readBypass,
  output logic                                   way1Valid,
  output logic                                   way2Valid,
  output logic [busPkg::addrBits-setBits-cachePkg::offsetBits-1:0] way1Tag,
  output logic [busPkg::addrBits-setBits-cachePkg::offsetBits-1:0] way2Tag,
  output logic [busPkg::dataBits-1:0]            instr
);

  localparam int tagBits = busPkg::addrBits - setBits - cachePkg::offsetBits;
  localparam int numSets = 1 << setBits;
  localparam int wordSelBits = $clog2(cachePkg::wordsPerLine);
  localparam int byteBits = cachePkg::offsetBits - wordSelBits;

  logic [busPkg::dataBits-1:0] dataMem [2][numSets][cachePkg::wordsPerLine];
  logic [tagBits-1:0]          tagMem [2][numSets];
  logic [numSets-1:0]          validBits [2];
  logic [busPkg::dataBits-1:0] bypassWord;

  logic [setBits-1:0]     setIdx;
  logic [wordSelBits-1:0] wordSel;
  logic [1:0]             wayWrite;

  assign setIdx = fetchAddr[cachePkg::offsetBits +: setBits];
  assign wordSel = fetchAddr[byteBits +: wordSelBits];
  assign wayWrite = {way2WriteEn, way1WriteEn};

  // Valid bit goes up with the tag on the final beat
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits[0] <= '0;
      validBits[1] <= '0;
    end else if (tagWrite) begin
      for (int w = 0; w < 2; w++) begin
        if (wayWrite[w]) begin
          validBits[w][setIdx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wayWrite[w]) begin
        dataMem[w][setIdx][fillWordOffset] <= busRdata;
        if (tagWrite) begin
          tagMem[w][setIdx] <= fetchAddr[busPkg::addrBits-1 -: tagBits];
        end
      end
    end
  end

  // Holds the word of an uncached fetch
  always_ff @(posedge clk) begin
    if (bypassLoad) begin
      bypassWord <= busRdata;
    end
  end

  assign way1Valid = validBits[0][setIdx];
  assign way2Valid = validBits[1][setIdx];
  assign way1Tag = tagMem[0][setIdx];
  assign way2Tag = tagMem[1][setIdx];

  assign instr = readBypass ? bypassWord : dataMem[readWay][setIdx][wordSel];

  // Fill targets exactly one way
  assert property (@(posedge clk) disable iff (reset) !(way1WriteEn && way2WriteEn))
    else $error("both ways written in one cycle");

endmodule

`default_nettype wire

// File: src/lruTable.sv
// One replacement bit per set. 0 picks way 1 next, 1 picks way 2
`timescale 1ns/1ns
`default_nettype none

module lruTable #(
  parameter int setBits = 6
) (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic [busPkg::addrBits-1:0] fetchAddr,
  input  wire logic                        lruUpdate,
  input  wire logic                        lruWay,
  output logic                             lruBit
);

  localparam int numSets = 1 << setBits;

  logic [numSets-1:0] lruBits;
  logic [setBits-1:0] setIdx;

  assign setIdx = fetchAddr[cachePkg::offsetBits +: setBits];

  // Point at the way that was not just used
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruUpdate) begin
      lruBits[setIdx] <= ~lruWay;
    end
  end

  assign lruBit = lruBits[setIdx];

endmodule

`default_nettype wire

// File: src/instrCache.sv
// Two-way instruction cache with a read-only burst bus port.
// Processor writes and invalidation are not supported
`timescale 1ns/1ns
`default_nettype none

module instrCache #(
  parameter int setBits = 6
) (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        cacheEnable,
  input  wire logic                        fetchValid,
  input  wire logic [busPkg::addrBits-1:0] fetchAddr,
  input  wire logic                        busReady,
  input  wire logic [busPkg::dataBits-1:0] busRdata,
  output logic [busPkg::dataBits-1:0]      instr,
  output logic                             stall,
  output logic [busPkg::addrBits-1:0]      busAddr,
  output busPkg::transType                 busTrans
);

  localparam int tagBits = busPkg::addrBits - setBits - cachePkg::offsetBits;
  localparam int wordSelBits = $clog2(cachePkg::wordsPerLine);

  logic                   way1Valid, way2Valid;
  logic [tagBits-1:0]     way1Tag, way2Tag;
  logic                   lruBit, lruUpdate, lruWay;
  logic                   way1WriteEn, way2WriteEn, tagWrite;
  logic [wordSelBits-1:0] fillWordOffset;
  logic                   readWay, bypassLoad, readBypass;

  cacheController #(.setBits(setBits)) cacheController_inst (
    .clk           (clk),
    .reset         (reset),
    .cacheEnable   (cacheEnable),
    .fetchValid    (fetchValid),
    .fetchAddr     (fetchAddr),
    .way1Valid     (way1Valid),
    .way2Valid     (way2Valid),
    .way1Tag       (way1Tag),
    .way2Tag       (way2Tag),
    .lruBit        (lruBit),
    .busReady      (busReady),
    .stall         (stall),
    .busAddr       (busAddr),
    .busTrans      (busTrans),
    .way1WriteEn   (way1WriteEn),
    .way2WriteEn   (way2WriteEn),
    .tagWrite      (tagWrite),
    .fillWordOffset(fillWordOffset),
    .readWay       (readWay),
    .bypassLoad    (bypassLoad),
    .readBypass    (readBypass),
    .lruUpdate     (lruUpdate),
    .lruWay        (lruWay)
  );

  cacheWays #(.setBits(setBits)) cacheWays_inst (
    .clk           (clk),
    .reset         (reset),
    .fetchAddr     (fetchAddr),
    .busRdata      (busRdata),
    .way1WriteEn   (way1WriteEn),
    .way2WriteEn   (way2WriteEn),
    .tagWrite      (tagWrite),
    .fillWordOffset(fillWordOffset),
    .readWay       (readWay),
    .bypassLoad    (bypassLoad),
    .readBypass    (readBypass),
    .way1Valid     (way1Valid),
    .way2Valid     (way2Valid),
    .way1Tag       (way1Tag),
    .way2Tag       (way2Tag),
    .instr         (instr)
  );

  lruTable #(.setBits(setBits)) lruTable_inst (
    .clk      (clk),
    .reset    (reset),
    .fetchAddr(fetchAddr),
    .lruUpdate(lruUpdate),
    .lruWay   (lruWay),
    .lruBit   (lruBit)
  );

endmodule

`default_nettype wire

// File: tests/busMemory.sv
// Read-only memory behind the bus. Every address is backed, and each word is
// a fixed function of its word address. busReady is low whenever waitNow is high
`timescale 1ns/1ns
`default_nettype none

module busMemory (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        waitNow,
  input  wire logic [busPkg::addrBits-1:0] busAddr,
  input  wire logic [1:0]                  busTrans,
  output logic                             busReady,
  output logic [busPkg::dataBits-1:0]      busRdata
);

  logic                        dataPending;
  logic [busPkg::addrBits-1:0] dataAddr;

  function automatic logic [busPkg::dataBits-1:0] contentAt(
    input logic [busPkg::addrBits-1:0] byteAddr
  );
    logic [busPkg::addrBits-1:0] wordAddr;
    wordAddr = byteAddr >> 2;
    return (wordAddr * 32'h9E37_79B1) ^ 32'hA5C3_0F1E;
  endfunction

  assign busReady = !waitNow;

  // A ready edge ends the current data phase and takes the next address phase
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      dataPending <= 1'b0;
      dataAddr <= '0;
    end else if (busReady) begin
      dataPending <= busTrans != busPkg::IDLE;
      dataAddr <= busAddr;
    end
  end

  assign busRdata = dataPending ? contentAt(dataAddr) : '0;

endmodule

`default_nettype wire

// File: tests/instrCacheTb.sv
// Self-checking testbench for instrCache with a reference model of tags,
// valid bits and LRU bits. Fetch and wait-state streams use separate LCG states
`timescale 1ns/1ns
`default_nettype none

module instrCacheTb;

  localparam int setBits = 6;
  localparam int numSets = 1 << setBits;
  localparam int tagBits = busPkg::addrBits - setBits - cachePkg::offsetBits;
  localparam int clkPeriod = 8;
  localparam int resetCycles = 16;
  localparam int unsigned seed = 69503;
  localparam int unsigned coldTag = 'h40;
  localparam int coldLines = 8;
  localparam int randomCount = 400;
  // Cold, hits, replacement, disabled, recheck and random fetches
  localparam int totalFetches = coldLines + coldLines * cachePkg::wordsPerLine + 8 + 6
                                + (coldLines + 2) + randomCount;
  // Four beats with up to four cycles each, plus request and delivery cycles
  localparam int timeoutNs = (totalFetches * (cachePkg::wordsPerLine * 4 + 4)
                              + resetCycles + 8) * clkPeriod;
  localparam logic [busPkg::addrBits-1:0] lineMask = (1 << cachePkg::offsetBits) - 1;

  logic                        clk, reset, cacheEnable, fetchValid, waitNow;
  logic                        stall, busReady;
  logic [busPkg::addrBits-1:0] fetchAddr, busAddr;
  logic [busPkg::dataBits-1:0] instr, busRdata;
  busPkg::transType            busTrans;

  // Reference model
  bit                 modelValid [2][numSets];
  logic [tagBits-1:0] modelTag [2][numSets];
  bit                 modelLru [numSets];

  // Accepted address phases of the current fetch
  logic [busPkg::addrBits-1:0] phaseAddrs [$];
  busPkg::transType            phaseKinds [$];

  int unsigned stimState = seed;
  int unsigned waitState = seed ^ 32'h2F6B_13C9;
  int checkCount = 0;
  int errCount = 0;
  int testCount = 0;
  int startChecks = 0;
  int startErrors = 0;

  instrCache #(.setBits(setBits)) instrCache_inst (
    .clk(clk), .reset(reset), .cacheEnable(cacheEnable), .fetchValid(fetchValid),
    .fetchAddr(fetchAddr), .busReady(busReady), .busRdata(busRdata), .instr(instr),
    .stall(stall), .busAddr(busAddr), .busTrans(busTrans)
  );

  busMemory busMemory_inst (
    .clk(clk), .reset(reset), .waitNow(waitNow), .busAddr(busAddr), .busTrans(busTrans),
    .busReady(busReady), .busRdata(busRdata)
  );

  function automatic int unsigned lcgStep(input int unsigned state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned randBelow(input int unsigned limit);
    stimState = lcgStep(stimState);
    return (stimState >> 16) % limit;
  endfunction

  // Word address times an odd constant, then xor
  function automatic logic [busPkg::dataBits-1:0] memWord(input logic [31:0] addr);
    logic [31:0] wordAddr;
    wordAddr = addr >> 2;
    return (wordAddr * 32'h9E37_79B1) ^ 32'hA5C3_0F1E;
  endfunction

  function automatic logic [31:0] makeAddr(input int unsigned tag, input int unsigned set,
                                           input int unsigned word);
    return (tag << (setBits + cachePkg::offsetBits)) | (set << cachePkg::offsetBits)
           | (word << 2);
  endfunction

  // Returns 1 on a hit, applies the hit or the fill to the model
  function automatic bit modelAccess(input logic [31:0] addr);
    logic [setBits-1:0] idx;
    logic [tagBits-1:0] tag;
    bit                 way;
    bit                 hit;
    idx = addr[cachePkg::offsetBits +: setBits];
    tag = addr[busPkg::addrBits-1 -: tagBits];
    hit = 1'b1;
    way = 1'b0;
    if (modelValid[1][idx] && modelTag[1][idx] == tag) begin
      way = 1'b1;
    end else if (!(modelValid[0][idx] && modelTag[0][idx] == tag)) begin
      hit = 1'b0;
      // Invalid way first, way 1 before way 2, else the LRU way
      if (!modelValid[0][idx]) begin
        way = 1'b0;
      end else if (!modelValid[1][idx]) begin
        way = 1'b1;
      end else begin
        way = modelLru[idx];
      end
      modelValid[way][idx] = 1'b1;
      modelTag[way][idx] = tag;
    end
    modelLru[idx] = !way;
    return hit;
  endfunction

  // Starts at a falling edge, ends at the falling edge after delivery
  task automatic runFetch(input logic [31:0] addr, input logic enable);
    logic [31:0]      gotWord;
    logic [31:0]      expAddr;
    busPkg::transType expKind;
    int               stallCycles;
    int               expPhases;
    int               i;
    bit               done;
    bit               expHit;
    phaseAddrs.delete();
    phaseKinds.delete();
    fetchAddr = addr;
    cacheEnable = enable;
    fetchValid = 1'b1;
    stallCycles = 0;
    done = 1'b0;
    gotWord = '0;
    while (!done) begin
      @(posedge clk);
      if (stall) begin
        stallCycles++;
      end else begin
        gotWord = instr;
        done = 1'b1;
      end
    end
    @(negedge clk);
    expHit = enable ? modelAccess(addr) : 1'b0;
    expPhases = expHit ? 0 : (enable ? cachePkg::wordsPerLine : 1);
    checkCount++;
    if (gotWord !== memWord(addr)) begin
      $display("MISMATCH instr: addr %h got %h expected %h", addr, gotWord, memWord(addr));
      errCount++;
    end
    if ((stallCycles != 0) == expHit) begin
      $display("MISMATCH stall: addr %h got %h expected %h", addr, stallCycles != 0, !expHit);
      errCount++;
    end
    if (phaseAddrs.size() != expPhases) begin
      $display("Fetch at %h produced %0d bus phases instead of %0d",
               addr, phaseAddrs.size(), expPhases);
      errCount++;
    end else begin
      for (i = 0; i < expPhases; i++) begin
        expAddr = enable ? (addr & ~lineMask) + (i << 2) : addr & ~32'd3;
        expKind = (i == 0) ? busPkg::NONSEQ : busPkg::SEQ;
        if (phaseAddrs[i] !== expAddr) begin
          $display("MISMATCH busAddr: phase %0d got %h expected %h", i, phaseAddrs[i], expAddr);
          errCount++;
        end
        if (phaseKinds[i] !== expKind) begin
          $display("MISMATCH busTrans: phase %0d got %h expected %h", i, phaseKinds[i], expKind);
          errCount++;
        end
      end
    end
  endtask

  task automatic reportTest(input string name);
    testCount++;
    $display("Test %0d %s: %0d checks, %0d errors", testCount, name,
             checkCount - startChecks, errCount - startErrors);
    startChecks = checkCount;
    startErrors = errCount;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Wait states, roughly one cycle in three
  initial begin
    waitNow = 1'b0;
    forever begin
      @(negedge clk);
      waitState = lcgStep(waitState);
      waitNow = ((waitState >> 16) % 3) == 0;
    end
  end

  always @(posedge clk) begin
    if (!reset && busReady && busTrans != busPkg::IDLE) begin
      phaseAddrs.push_back(busAddr);
      phaseKinds.push_back(busTrans);
    end
  end

  initial begin
    #(timeoutNs);
    $display("Timeout after %0d ns, a fetch was never delivered", timeoutNs);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int          n;
    int          w;
    int unsigned set;
    int unsigned tag;
    int unsigned word;
    logic        en;
    reset = 1'b1;
    cacheEnable = 1'b1;
    fetchValid = 1'b0;
    fetchAddr = '0;
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checkCount++;
    if (busTrans !== busPkg::IDLE) begin
      $display("MISMATCH busTrans: got %h expected %h", busTrans, busPkg::IDLE);
      errCount++;
    end
    if (stall !== 1'b0) begin
      $display("MISMATCH stall: got %h expected %h", stall, 1'b0);
      errCount++;
    end
    reportTest("reset");
    for (n = 0; n < coldLines; n++) begin
      runFetch(makeAddr(coldTag, n, n % 4), 1'b1);
    end
    reportTest("cold misses");
    for (n = 0; n < coldLines; n++) begin
      for (w = 0; w < cachePkg::wordsPerLine; w++) begin
        runFetch(makeAddr(coldTag, n, w), 1'b1);
      end
    end
    reportTest("hits");
    // A and B fill set 20, C evicts B, B evicts C, C evicts A, A evicts B
    runFetch(makeAddr('h21, 20, 2), 1'b1);
    runFetch(makeAddr('h22, 20, 2), 1'b1);
    runFetch(makeAddr('h21, 20, 2), 1'b1);
    runFetch(makeAddr('h23, 20, 2), 1'b1);
    runFetch(makeAddr('h21, 20, 2), 1'b1);
    runFetch(makeAddr('h22, 20, 2), 1'b1);
    runFetch(makeAddr('h23, 20, 2), 1'b1);
    runFetch(makeAddr('h21, 20, 2), 1'b1);
    reportTest("replacement");
    // Other tags in cached sets, at the word that is read back below
    for (n = 0; n < 4; n++) begin
      runFetch(makeAddr(coldTag + 1, n * 2, 1), 1'b0);
    end
    runFetch(makeAddr('h31, 40, 0), 1'b0);
    runFetch(makeAddr('h32, 40, 1), 1'b0);
    // Cached lines must still hit, uncached ones must still miss
    for (n = 0; n < coldLines; n++) begin
      runFetch(makeAddr(coldTag, n, 1), 1'b1);
    end
    runFetch(makeAddr('h31, 40, 2), 1'b1);
    runFetch(makeAddr('h32, 40, 1), 1'b1);
    reportTest("disabled fetches");
    for (n = 0; n < randomCount; n++) begin
      set = randBelow(4);
      tag = coldTag + randBelow(6);
      word = randBelow(cachePkg::wordsPerLine);
      en = randBelow(5) != 0;
      runFetch(makeAddr(tag, set, word), en);
    end
    reportTest("random mix");
    fetchValid = 1'b0;
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/busPkg.sv
src/cachePkg.sv
src/cacheController.sv
src/cacheWays.sv
src/lruTable.sv
src/instrCache.sv
tests/busMemory.sv
tests/instrCacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns --top-module instrCacheTb \
  -f sources.f -Mdir obj_dir -o instrCacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/instrCacheSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "FAIL: see errors above" "$logFile"; then
  exit 1
fi
exit 0
